// File: Bender.yml
package:
  name: dehaze

sources:
  - include_dirs:
      - source
    files:
      - source/dehaze_pkg.sv
      - source/recovery_if.sv
      - source/pipe_delay.sv
      - source/transmission_estimator.sv
      - source/scene_recovery.sv
      - source/dehaze_top.sv
  - target: test
    include_dirs:
      - source
      - bench
    files:
      - bench/tb_dehaze.sv

// File: bench/dehaze_model.svh
// Reference model and compare tasks for the dehazing testbench, included inside the testbench module
`ifndef DEHAZE_MODEL_SVH
`define DEHAZE_MODEL_SVH

// ====================
// Reference model
// ====================

// Channel 0 is red, 1 green, 2 blue
function automatic int window_mean(window_t w, int ch);
    int sum;
    sum = 0;
    for (int k = 0; k < 9; k++) begin
        sum += (ch == 0) ? int'(w[k].r) : (ch == 1) ? int'(w[k].g) : int'(w[k].b);
    end
    return (sum * `DH_MEAN_MUL) >> `DH_MEAN_SHIFT;
endfunction

// Darkest mean wins, earlier channel kept on a tie
function automatic int transmission(window_t w, inv_light_t il);
    int best;
    int prod;
    int t;
    int inv [3];
    inv = '{int'(il.r), int'(il.g), int'(il.b)};
    best = 0;
    for (int ch = 1; ch < 3; ch++) begin
        if (window_mean(w, ch) < window_mean(w, best)) begin
            best = ch;
        end
    end
    prod = window_mean(w, best) * inv[best];
    t = 65535 - ((prod > 65535) ? 65535 : prod);
    return (t < `DH_T_MIN) ? `DH_T_MIN : t;
endfunction

// Light moved away by the scaled distance, clipped to the channel range
function automatic chan_t recover_value(int p, int a, int inv_t);
    int q;
    q = (((p >= a) ? p - a : a - p) * inv_t) >> `DH_INV_T_SHIFT;
    q = (q > 255) ? 255 : q;
    if (p >= a) begin
        return chan_t'((a + q > 255) ? 255 : a + q);
    end
    return chan_t'((a < q) ? 0 : a - q);
endfunction

function automatic pixel_t expected_pixel(window_t w, pixel_t a, inv_light_t il);
    longint inv_t;
    pixel_t p;
    // 1/t with 12 fraction bits, taken at the middle of the bin of the top byte of t
    inv_t = (longint'(1) << 28) / (256 * (transmission(w, il) >> 8) + 128);
    inv_t = (inv_t > 65535) ? 65535 : inv_t;
    p.r = recover_value(int'(w[4].r), int'(a.r), int'(inv_t));
    p.g = recover_value(int'(w[4].g), int'(a.g), int'(inv_t));
    p.b = recover_value(int'(w[4].b), int'(a.b), int'(inv_t));
    return p;
endfunction

// ====================
// Compare tasks
// ====================

task automatic compare_pixel(pixel_t got, pixel_t want, string what);
    if (got !== want) begin
        abort_run($sformatf("FAIL %0.1f ns: %s is %h, expected %h",
                            $realtime, what, got, want));
    end
endtask

task automatic compare_flag(logic got, logic want, string what);
    if (got !== want) begin
        abort_run($sformatf("FAIL %0.1f ns: %s is %b, expected %b",
                            $realtime, what, got, want));
    end
endtask

`endif

// File: bench/tb_dehaze.sv
// Self-checking testbench for dehaze_top, seeded random windows checked against a model
`timescale 1ns/1ps
`default_nettype none

`include "dehaze_consts.svh"

module tb_dehaze import dehaze_pkg::*; ();

    localparam int frame_pixels = 64;
    localparam int latency      = 6;

    typedef struct packed {
        logic [31:0] due;
        pixel_t      pix;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        in_valid;
    window_t     window;
    pixel_t      light;
    inv_light_t  inv_light;
    pixel_t      pixel_out;
    logic        out_valid;
    logic        done;

    expect_t     exp_q [$];
    int unsigned edge_count = 0;
    int unsigned accepted;
    int unsigned done_due;
    logic        checking;

    dehaze_top #(
        .image_pixels (frame_pixels)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .window    (window),
        .light     (light),
        .inv_light (inv_light),
        .pixel_out (pixel_out),
        .out_valid (out_valid),
        .done      (done)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    task automatic abort_run(string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_timeout(string what);
        abort_run($sformatf("Timeout at %0.1f ns: %s", $realtime, what));
    endtask

`include "dehaze_model.svh"

    // ====================
    // Stimulus
    // ====================

    function automatic int rand_range(int lo, int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    function automatic pixel_t rand_pixel(int lo, int hi);
        pixel_t p;
        p.r = chan_t'(rand_range(lo, hi));
        p.g = chan_t'(rand_range(lo, hi));
        p.b = chan_t'(rand_range(lo, hi));
        return p;
    endfunction

    // Surround in lo..hi, centre free over the full range
    function automatic window_t rand_window(int lo, int hi);
        window_t w;
        for (int k = 0; k < 9; k++) begin
            w[k] = rand_pixel(lo, hi);
        end
        w[4] = rand_pixel(0, 255);
        return w;
    endfunction

    function automatic inv_light_t light_reciprocals(pixel_t a);
        inv_light_t il;
        il.r = q16_t'(65535 / int'(a.r));
        il.g = q16_t'(65535 / int'(a.g));
        il.b = q16_t'(65535 / int'(a.b));
        return il;
    endfunction

    // Inputs change just after an edge and the expected pixel is due six edges later
    task automatic apply_input(logic valid, window_t w, pixel_t a);
        inv_light_t il;
        expect_t    item;
        il = light_reciprocals(a);
        @(posedge clk);
        #0.5;
        in_valid  = valid;
        window    = w;
        light     = a;
        inv_light = il;
        if (valid) begin
            item.due = edge_count + latency;
            item.pix = expected_pixel(w, a, il);
            exp_q.push_back(item);
            accepted++;
            if (accepted == frame_pixels) begin
                done_due = edge_count + 2;
            end
        end
    endtask

    task automatic wait_for_done();
        int waited;
        waited = 0;
        while (done !== 1'b1) begin
            apply_input(1'b0, rand_window(0, 255), rand_pixel(1, 255));
            waited++;
            if (waited > 8) begin
                report_timeout("done did not rise after the last window of the frame");
            end
        end
    endtask

    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            apply_input(1'b0, rand_window(0, 255), rand_pixel(1, 255));
            waited++;
            if (waited > latency + 4) begin
                report_timeout("not every accepted window produced an output pixel");
            end
        end
    endtask

    // ====================
    // Scoreboard
    // ====================

    task automatic check_outputs();
        logic    due_now;
        expect_t item;
        due_now = (exp_q.size() != 0) && (exp_q[0].due == edge_count);
        compare_flag(out_valid, due_now, "out_valid");
        if (due_now) begin
            item = exp_q.pop_front();
            compare_pixel(pixel_out, item.pix, "pixel_out");
        end
        compare_flag(done, edge_count >= done_due, "done");
    endtask

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (checking) begin
            check_outputs();
        end
    end

    initial begin
        int     waited;
        pixel_t a;
        void'($urandom(32'h634ed51d));
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        window    = '0;
        light     = '0;
        inv_light = '0;
        checking  = 1'b0;
        accepted  = 0;
        done_due  = '1;
        repeat (5) @(posedge clk);
        #0.5;
        rst      = 1'b0;
        checking = 1'b1;
        compare_flag(out_valid, 1'b0, "out_valid after reset");
        compare_flag(done, 1'b0, "done after reset");

        // Fill one frame with gapped random input
        waited = 0;
        while (accepted < frame_pixels) begin
            apply_input(rand_range(0, 3) != 0, rand_window(0, 255), rand_pixel(1, 255));
            waited++;
            if (waited > 400) begin
                report_timeout("the windows of the first frame were not all accepted");
            end
        end
        wait_for_done();

        // Back to back
        repeat (24) apply_input(1'b1, rand_window(0, 255), rand_pixel(1, 255));

        // Window equal to the light everywhere
        repeat (10) begin
            a = rand_pixel(1, 255);
            apply_input(1'b1, {9{a}}, a);
        end

        // Bright surround under dim light drives t onto its floor
        repeat (40) apply_input(rand_range(0, 3) != 0, rand_window(200, 255), rand_pixel(1, 40));

        repeat (60) apply_input(rand_range(0, 3) != 0, rand_window(0, 255), rand_pixel(1, 255));

        drain_outputs();
        // Idle tail catches any extra out_valid
        repeat (8) apply_input(1'b0, rand_window(0, 255), rand_pixel(1, 255));
        compare_flag(done, 1'b1, "done at end of run");
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: source/dehaze_consts.svh
// Widths, frame size and fixed-point constants for the dehazing pipeline, included where needed
`ifndef DEHAZE_CONSTS_SVH
`define DEHAZE_CONSTS_SVH

// ====================
// Data widths
// ====================

// One colour channel
`define DH_CHAN_W 8

// Unsigned fixed-point word
`define DH_Q16_W 16

// ====================
// Frame and arithmetic
// ====================

// Default frame size in pixels
`define DH_IMAGE_PIXELS (512 * 512)

// Lowest transmission, 0.1 in Q0.16
`define DH_T_MIN 6554

// Multiply then shift approximates a division by nine
`define DH_MEAN_MUL 57
`define DH_MEAN_SHIFT 9

// Fraction bits of the transmission reciprocal
`define DH_INV_T_SHIFT 12

`endif

// File: source/dehaze_pkg.sv
// Pixel, window and fixed-point types plus the reciprocal table entry, imported by wildcard
`default_nettype none

`include "dehaze_consts.svh"

package dehaze_pkg;

    typedef logic [`DH_CHAN_W-1:0] chan_t;
    typedef logic [`DH_Q16_W-1:0]  q16_t;

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } pixel_t;

    // Nine pixels in row order, element 4 is the centre
    typedef pixel_t [8:0] window_t;

    // Per-channel reciprocal of the atmospheric light, 65535 means 1
    typedef struct packed {
        q16_t r;
        q16_t g;
        q16_t b;
    } inv_light_t;

    // ====================
    // Reciprocal table
    // ====================

    // 2^28 / (256 * idx + 128), i.e. 1/t with 12 fraction bits taken at the bin centre
    function automatic q16_t recip_entry(input chan_t idx);
        logic [31:0] den;
        logic [31:0] quo;
        den = (32'(idx) << 8) + 32'd128;
        quo = 32'h1000_0000 / den;
        if (quo > 32'd65535) begin
            return '1;
        end
        return quo[`DH_Q16_W-1:0];
    endfunction

endpackage

`default_nettype wire

// File: source/dehaze_top.sv
// Dehazing pipeline top level, one 3x3 window in and one recovered pixel out six cycles later
`timescale 1ns/1ps
`default_nettype none

`include "dehaze_consts.svh"

module dehaze_top import dehaze_pkg::*; #(
    parameter int image_pixels = `DH_IMAGE_PIXELS
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  window_t    window,
    input  pixel_t     light,
    input  inv_light_t inv_light,
    output pixel_t     pixel_out,
    output logic       out_valid,
    output logic       done
);

    // Side data must wait as long as the estimator
    localparam int est_latency = 4;
    localparam int cnt_w       = $clog2(image_pixels + 1);

    // ====================
    // Frame counter
    // ====================

    logic [cnt_w-1:0] pixel_count;

    // Counter stops at the frame size, done follows one edge later and holds
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pixel_count <= '0;
            done        <= 1'b0;
        end else begin
            if (in_valid && pixel_count != cnt_w'(image_pixels)) begin
                pixel_count <= pixel_count + 1'b1;
            end
            if (pixel_count == cnt_w'(image_pixels)) begin
                done <= 1'b1;
            end
        end
    end

    // ====================
    // Pipeline
    // ====================

    recovery_if rec_if ();

    transmission_estimator est_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .window    (window),
        .inv_light (inv_light),
        .est       (rec_if.estimate)
    );

    // Centre pixel
    pipe_delay #(
        .payload_t (pixel_t),
        .depth     (est_latency)
    ) pixel_delay_i (
        .clk  (clk),
        .rst  (rst),
        .din  (window[4]),
        .dout (rec_if.pixel)
    );

    pipe_delay #(
        .payload_t (pixel_t),
        .depth     (est_latency)
    ) light_delay_i (
        .clk  (clk),
        .rst  (rst),
        .din  (light),
        .dout (rec_if.light)
    );

    scene_recovery rec_i (
        .clk       (clk),
        .rst       (rst),
        .rec       (rec_if.recover),
        .pixel_out (pixel_out),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

// File: source/pipe_delay.sv
// Fixed-depth shift register that keeps side data in step with the estimator stages
`timescale 1ns/1ps
`default_nettype none

module pipe_delay #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t din,
    output payload_t dout
);

    payload_t stages [depth];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= din;
            for (int i = 1; i < depth; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    // Oldest entry leaves the line
    assign dout = stages[depth-1];

endmodule

`default_nettype wire

// File: source/recovery_if.sv
// Aligned item from transmission estimation to scene recovery, one per valid cycle
`timescale 1ns/1ps
`default_nettype none

interface recovery_if import dehaze_pkg::*; ();

    logic   valid;
    q16_t   inv_t;
    pixel_t pixel;
    pixel_t light;

    // Estimator side
    modport estimate (output valid, output inv_t);

    // Delay lines for the centre pixel and the light
    modport align (output pixel, output light);

    // Scene recovery side
    modport recover (
        input valid,
        input inv_t,
        input pixel,
        input light
    );

endinterface

`default_nettype wire

// File: source/scene_recovery.sv
// Two-stage scene recovery, J = A +/- |I - A| / t with saturation to the channel range
`timescale 1ns/1ps
`default_nettype none

`include "dehaze_consts.svh"

module scene_recovery import dehaze_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    recovery_if.recover rec,
    output pixel_t pixel_out,
    output logic   out_valid
);

    // |I - A| scaled by 1/t, capped at full scale
    function automatic chan_t scale_diff(input chan_t pix, input chan_t light, input q16_t inv_t);
        chan_t                           d;
        logic [`DH_CHAN_W+`DH_Q16_W-1:0] prod;
        logic [`DH_CHAN_W+`DH_Q16_W-1:0] shifted;
        d       = (pix >= light) ? (pix - light) : (light - pix);
        prod    = d * inv_t;
        shifted = prod >> `DH_INV_T_SHIFT;
        return (shifted > 255) ? '1 : shifted[`DH_CHAN_W-1:0];
    endfunction

    // Saturating add when the pixel is brighter than the light, otherwise saturating subtract
    function automatic chan_t recover_chan(input chan_t light, input chan_t q, input logic up);
        logic [`DH_CHAN_W:0] sum;
        sum = light + q;
        if (up) begin
            return sum[`DH_CHAN_W] ? '1 : sum[`DH_CHAN_W-1:0];
        end
        return (light >= q) ? (light - q) : '0;
    endfunction

    // ====================
    // Stage 1
    // ====================

    pixel_t     q_q;
    pixel_t     light_q;
    logic [2:0] up_q;
    logic       valid_s1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q_q      <= '0;
            light_q  <= '0;
            up_q     <= '0;
            valid_s1 <= 1'b0;
        end else begin
            q_q.r    <= scale_diff(rec.pixel.r, rec.light.r, rec.inv_t);
            q_q.g    <= scale_diff(rec.pixel.g, rec.light.g, rec.inv_t);
            q_q.b    <= scale_diff(rec.pixel.b, rec.light.b, rec.inv_t);
            up_q     <= {rec.pixel.r >= rec.light.r,
                         rec.pixel.g >= rec.light.g,
                         rec.pixel.b >= rec.light.b};
            light_q  <= rec.light;
            valid_s1 <= rec.valid;
        end
    end

    // ====================
    // Stage 2
    // ====================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pixel_out <= '0;
            out_valid <= 1'b0;
        end else begin
            pixel_out.r <= recover_chan(light_q.r, q_q.r, up_q[2]);
            pixel_out.g <= recover_chan(light_q.g, q_q.g, up_q[1]);
            pixel_out.b <= recover_chan(light_q.b, q_q.b, up_q[0]);
            out_valid   <= valid_s1;
        end
    end

endmodule

`default_nettype wire

// File: source/transmission_estimator.sv
// Four-stage transmission estimate from a 3x3 window, drives the reciprocal onto recovery_if
`timescale 1ns/1ps
`default_nettype none

`include "dehaze_consts.svh"

module transmission_estimator import dehaze_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  window_t    window,
    input  inv_light_t inv_light,
    recovery_if.estimate est
);

    // Sum of nine channel values
    localparam int sum_w = `DH_CHAN_W + 4;

    function automatic chan_t scaled_mean(input logic [sum_w-1:0] sum);
        logic [sum_w+5:0] prod;
        prod = (sum_w + 6)'(sum) * (sum_w + 6)'(`DH_MEAN_MUL);
        return chan_t'(prod >> `DH_MEAN_SHIFT);
    endfunction

    // ====================
    // Stage 1
    // ====================

    logic [sum_w-1:0] sum_r;
    logic [sum_w-1:0] sum_g;
    logic [sum_w-1:0] sum_b;
    pixel_t           mean_q;
    inv_light_t       inv_q;
    logic             valid_s1;

    always_comb begin
        sum_r = '0;
        sum_g = '0;
        sum_b = '0;
        for (int k = 0; k < 9; k++) begin
            sum_r = sum_r + sum_w'(window[k].r);
            sum_g = sum_g + sum_w'(window[k].g);
            sum_b = sum_b + sum_w'(window[k].b);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mean_q   <= '0;
            inv_q    <= '0;
            valid_s1 <= 1'b0;
        end else begin
            mean_q.r <= scaled_mean(sum_r);
            mean_q.g <= scaled_mean(sum_g);
            mean_q.b <= scaled_mean(sum_b);
            inv_q    <= inv_light;
            valid_s1 <= in_valid;
        end
    end

    // ====================
    // Stage 2
    // ====================

    chan_t min_mean;
    q16_t  min_inv;
    chan_t min_mean_q;
    q16_t  min_inv_q;
    logic  valid_s2;

    // Dark channel pick, ties favour red then green
    always_comb begin
        if (mean_q.r <= mean_q.g && mean_q.r <= mean_q.b) begin
            min_mean = mean_q.r;
            min_inv  = inv_q.r;
        end else if (mean_q.g <= mean_q.b) begin
            min_mean = mean_q.g;
            min_inv  = inv_q.g;
        end else begin
            min_mean = mean_q.b;
            min_inv  = inv_q.b;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            min_mean_q <= '0;
            min_inv_q  <= '0;
            valid_s2   <= 1'b0;
        end else begin
            min_mean_q <= min_mean;
            min_inv_q  <= min_inv;
            valid_s2   <= valid_s1;
        end
    end

    // ====================
    // Stage 3
    // ====================

    logic [`DH_CHAN_W+`DH_Q16_W-1:0] dark_prod;
    q16_t                            dark_sat;
    q16_t                            t_raw;
    q16_t                            t_q;
    logic                            valid_s3;

    assign dark_prod = min_mean_q * min_inv_q;
    assign dark_sat  = (|dark_prod[`DH_CHAN_W+`DH_Q16_W-1:`DH_Q16_W]) ?
                       '1 : dark_prod[`DH_Q16_W-1:0];
    assign t_raw     = '1 - dark_sat;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            t_q      <= '0;
            valid_s3 <= 1'b0;
        end else begin
            t_q      <= (t_raw < q16_t'(`DH_T_MIN)) ? q16_t'(`DH_T_MIN) : t_raw;
            valid_s3 <= valid_s2;
        end
    end

    // ====================
    // Stage 4
    // ====================

    // Reciprocal table indexed by the top byte of t
    q16_t recip_rom [256];
    q16_t inv_t_q;
    logic valid_s4;

    for (genvar k = 0; k < 256; k++) begin : g_recip
        assign recip_rom[k] = recip_entry(chan_t'(k));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            inv_t_q  <= '0;
            valid_s4 <= 1'b0;
        end else begin
            inv_t_q  <= recip_rom[t_q[`DH_Q16_W-1:`DH_Q16_W-8]];
            valid_s4 <= valid_s3;
        end
    end

    assign est.inv_t = inv_t_q;
    assign est.valid = valid_s4;

endmodule

`default_nettype wire

// File: src.f
+incdir+source
+incdir+bench
source/dehaze_pkg.sv
source/recovery_if.sv
source/pipe_delay.sv
source/transmission_estimator.sv
source/scene_recovery.sv
source/dehaze_top.sv
bench/tb_dehaze.sv
